/* src.f */
+incdir+.
fetch_pkg.sv
pc_gen.sv
imem_bank.sv
if_stage.sv
fetch_top.sv
tb_clock_gen.sv
fetch_tb.sv

/* Bender.yml */
package:
  name: fetch_front_end

sources:
  - include_dirs:
      - .
    files:
      - fetch_pkg.sv
      - pc_gen.sv
      - imem_bank.sv
      - if_stage.sv
      - fetch_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - fetch_tb.sv

/* fetch_tb.sv */
`include "fetch_macros.svh"

module fetch_tb;

    localparam int PROG_WORDS = `BANK_COUNT * `BANK_DEPTH;
    localparam int WAIT_LIMIT = 500;

    logic                  clk;
    logic                  rst_n;
    logic                  jump;
    fetch_pkg::addr_t      jump_addr;
    logic                  fence_flush;
    logic                  halt;
    logic                  clint_hold;
    fetch_pkg::bank_mask_t mem_stall;
    logic                  out_ready;
    logic                  wr_en;
    fetch_pkg::addr_t      wr_addr;
    fetch_pkg::inst_t      wr_data;
    logic                  inst_valid;
    fetch_pkg::inst_t      inst;
    fetch_pkg::addr_t      inst_pc;

    // program image as written through the load port
    fetch_pkg::inst_t prog [PROG_WORDS];

    // reference model of the fetch stream
    fetch_pkg::addr_t seq_pc;
    fetch_pkg::addr_t jump_target;
    logic             jump_pending;
    int               pre_left;

    // output seen stalled on the previous edge
    logic             held;
    fetch_pkg::addr_t held_pc;
    fetch_pkg::inst_t held_inst;

    int taken;
    int checks;
    int errors;
    int tests;

    tb_clock_gen clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    fetch_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .jump        (jump),
        .jump_addr   (jump_addr),
        .fence_flush (fence_flush),
        .halt        (halt),
        .clint_hold  (clint_hold),
        .mem_stall   (mem_stall),
        .out_ready   (out_ready),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .inst_pc     (inst_pc)
    );

    //////////////////////////////////////////////////////////////////////
    // reference model and output monitor
    //////////////////////////////////////////////////////////////////////

    // the banks hold only PROG_WORDS words so higher address bits wrap
    function automatic fetch_pkg::inst_t word_at(input fetch_pkg::addr_t pc);
        return prog[(pc >> 2) % PROG_WORDS];
    endfunction

    // older items may still drain before a jump target shows up
    task automatic check_item(input fetch_pkg::addr_t pc, input fetch_pkg::inst_t data);
        fetch_pkg::addr_t exp_pc;
        if (jump_pending && (pre_left == 0 || pc == jump_target)) begin
            exp_pc       = jump_target;
            jump_pending = 1'b0;
        end else begin
            exp_pc = seq_pc;
            if (jump_pending) begin
                pre_left--;
            end
        end
        checks += 2;
        assert (pc == exp_pc) else begin
            $display("Mismatch at time %0t: inst_pc %h, expected %h", $time, pc, exp_pc);
            errors++;
        end
        assert (data == word_at(exp_pc)) else begin
            $display("Mismatch at time %0t: inst %h at pc %h, expected %h",
                     $time, data, exp_pc, word_at(exp_pc));
            errors++;
        end
        seq_pc = exp_pc + 32'd4;
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (held) begin
                checks++;
                assert (inst_valid && inst_pc == held_pc && inst == held_inst) else begin
                    $display("Mismatch at time %0t: output moved while held, pc %h inst %h",
                             $time, inst_pc, inst);
                    errors++;
                end
            end
            if (inst_valid && out_ready) begin
                check_item(inst_pc, inst);
                taken++;
            end
            held      = inst_valid && !out_ready;
            held_pc   = inst_pc;
            held_inst = inst;
        end else begin
            held = 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        while (!rst_n && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        assert (rst_n) else begin
            $display("Reset was never released");
            errors++;
        end
    endtask

    task automatic load_program();
        checks++;
        assert (!inst_valid) else begin
            $display("Mismatch at time %0t: inst_valid high right after reset", $time);
            errors++;
        end
        for (int k = 0; k < PROG_WORDS; k++) begin
            @(negedge clk);
            wr_en   = 1'b1;
            wr_addr = fetch_pkg::addr_t'(k * 4);
            wr_data = $urandom;
            prog[k] = wr_data;
        end
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    // wait for n more taken items while optionally shaking stalls or ready
    task automatic wait_items(input int n, input string what, input bit rand_stall,
                              input bit rand_ready);
        int target;
        int cycles;
        target = taken + n;
        cycles = 0;
        while (taken < target && cycles < WAIT_LIMIT) begin
            if (rand_stall) begin
                mem_stall = fetch_pkg::bank_mask_t'($urandom);
            end
            if (rand_ready) begin
                out_ready = $urandom % 2;
            end
            @(negedge clk);
            cycles++;
        end
        assert (taken >= target) else begin
            $display("Timeout in %s: only %0d of %0d instructions after %0d cycles",
                     what, n - (target - taken), n, cycles);
            errors++;
        end
    endtask

    // one cycle jump pulse from a falling edge
    // older is how many already fetched items may still come out first
    task automatic pulse_jump(input fetch_pkg::addr_t target, input int older);
        jump         = 1'b1;
        jump_addr    = target;
        jump_pending = 1'b1;
        jump_target  = target;
        pre_left     = older;
        @(negedge clk);
        jump = 1'b0;
    endtask

    task automatic expect_jump_done(input string what);
        assert (!jump_pending) else begin
            $display("%s: jump target %h never reached the output", what, jump_target);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        $display("%s finished with %0d errors", name, errors - err_before);
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_sequential();
        int err_before;
        err_before = errors;
        wait_items(20, "sequential fetch", 1'b0, 1'b0);
        report_test("sequential fetch", err_before);
    endtask

    task automatic test_jump();
        int err_before;
        err_before = errors;
        wait_items(4, "jump lead-in", 1'b0, 1'b0);
        pulse_jump(32'h0000_0200, 2);
        wait_items(12, "jump", 1'b0, 1'b0);
        expect_jump_done("jump");
        report_test("jump", err_before);
    endtask

    // jump lands while requests are cancelled, so it must be saved
    // the buffer drains during the hold and the target comes out first
    task automatic test_saved_jump();
        int err_before;
        err_before = errors;
        clint_hold = 1'b1;
        repeat (4) @(negedge clk);
        pulse_jump(32'h0000_0080, 0);
        repeat (3) @(negedge clk);
        clint_hold = 1'b0;
        wait_items(8, "saved jump under clint_hold", 1'b0, 1'b0);
        expect_jump_done("saved jump under clint_hold");
        fence_flush = 1'b1;
        repeat (4) @(negedge clk);
        pulse_jump(32'h0000_0300, 0);
        repeat (3) @(negedge clk);
        fence_flush = 1'b0;
        wait_items(8, "saved jump under fence_flush", 1'b0, 1'b0);
        expect_jump_done("saved jump under fence_flush");
        report_test("saved jump", err_before);
    endtask

    task automatic test_bank_stalls();
        int err_before;
        err_before = errors;
        wait_items(40, "bank stalls", 1'b1, 1'b0);
        mem_stall = '0;
        report_test("bank stalls", err_before);
    endtask

    task automatic test_back_pressure();
        int err_before;
        err_before = errors;
        wait_items(40, "back-pressure", 1'b0, 1'b1);
        out_ready = 1'b1;
        report_test("back-pressure", err_before);
    endtask

    initial begin
        void'($urandom(18950));
        jump         = 1'b0;
        jump_addr    = '0;
        fence_flush  = 1'b0;
        halt         = 1'b1;
        clint_hold   = 1'b0;
        mem_stall    = '0;
        out_ready    = 1'b1;
        wr_en        = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        seq_pc       = `RESET_PC;
        jump_target  = '0;
        jump_pending = 1'b0;
        pre_left     = 0;
        held         = 1'b0;
        taken        = 0;
        checks       = 0;
        errors       = 0;
        tests        = 0;

        // halt keeps fetch idle until the program is in place
        wait_reset();
        load_program();
        halt = 1'b0;

        test_sequential();
        test_jump();
        test_saved_jump();
        test_bank_stalls();
        test_back_pressure();

        $display("%0d tests, %0d items, %0d checks, %0d errors", tests, taken, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // free running clock, period 10
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for five rising edges, released between edges
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* fetch_top.sv */
`include "fetch_macros.svh"

module fetch_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   jump,
    input  fetch_pkg::addr_t       jump_addr,
    input  logic                   fence_flush,
    input  logic                   halt,
    input  logic                   clint_hold,
    input  fetch_pkg::bank_mask_t  mem_stall,
    input  logic                   out_ready,
    input  logic                   wr_en,
    input  fetch_pkg::addr_t       wr_addr,
    input  fetch_pkg::inst_t       wr_data,
    output logic                   inst_valid,
    output fetch_pkg::inst_t       inst,
    output fetch_pkg::addr_t       inst_pc
);

    logic             rom_req;
    fetch_pkg::addr_t next_pc;
    fetch_pkg::addr_t pc_if;
    logic             mem_addr_ok;
    logic             allow_in_if;

    fetch_pkg::bank_mask_t                bank_addr_ok;
    fetch_pkg::bank_mask_t                bank_rvalid;
    fetch_pkg::inst_t [`BANK_COUNT-1:0]   bank_rdata;

    ////////////////////////////////////////////////////////////////////
    // pre-fetch pc generator
    ////////////////////////////////////////////////////////////////////

    pc_gen u_pc_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .jump_addr   (jump_addr),
        .jump        (jump),
        .fence_flush (fence_flush),
        .halt        (halt),
        .clint_hold  (clint_hold),
        .allow_in_if (allow_in_if),
        .mem_addr_ok (mem_addr_ok),
        .pc_if       (pc_if),
        .rom_req     (rom_req),
        .next_pc     (next_pc)
    );

    // word interleaved banks, all see the same request
    for (genvar g = 0; g < `BANK_COUNT; g++) begin : g_bank
        imem_bank #(
            .BANK_ID (g)
        ) u_bank (
            .clk     (clk),
            .rst_n   (rst_n),
            .req     (rom_req),
            .addr    (next_pc),
            .stall   (mem_stall[g]),
            .wr_en   (wr_en),
            .wr_addr (wr_addr),
            .wr_data (wr_data),
            .addr_ok (bank_addr_ok[g]),
            .rvalid  (bank_rvalid[g]),
            .rdata   (bank_rdata[g])
        );
    end

    if_stage u_if_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .rom_req      (rom_req),
        .next_pc      (next_pc),
        .bank_addr_ok (bank_addr_ok),
        .bank_rvalid  (bank_rvalid),
        .bank_rdata   (bank_rdata),
        .out_ready    (out_ready),
        .mem_addr_ok  (mem_addr_ok),
        .pc_if        (pc_if),
        .allow_in_if  (allow_in_if),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .inst_pc      (inst_pc)
    );

endmodule

/* if_stage.sv */
`include "fetch_macros.svh"

module if_stage (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 rom_req,
    input  fetch_pkg::addr_t                     next_pc,
    input  fetch_pkg::bank_mask_t                bank_addr_ok,
    input  fetch_pkg::bank_mask_t                bank_rvalid,
    input  fetch_pkg::inst_t [`BANK_COUNT-1:0]   bank_rdata,
    input  logic                                 out_ready,
    output logic                                 mem_addr_ok,
    output fetch_pkg::addr_t                     pc_if,
    output logic                                 allow_in_if,
    output logic                                 inst_valid,
    output fetch_pkg::inst_t                     inst,
    output fetch_pkg::addr_t                     inst_pc
);

    fetch_pkg::bank_sel_t next_bank;

    // two entry in-order buffer, in-flight entries included
    fetch_pkg::addr_t     ent_pc   [2];
    fetch_pkg::bank_sel_t ent_bank [2];
    fetch_pkg::inst_t     ent_data [2];
    logic [1:0]           ent_dvalid;
    logic [1:0]           ent_busy;
    logic [1:0]           fill_hit;

    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    assign next_bank   = next_pc[`BANK_SEL_W+1:2];
    assign mem_addr_ok = bank_addr_ok[next_bank];

    // ready_go_pre, as seen from this side
    assign push = rom_req && mem_addr_ok;
    assign pop  = inst_valid && out_ready;

    assign allow_in_if = count < 2'd2;

    // head goes out once its word is back
    assign inst_valid = (count != 2'd0) && ent_dvalid[rd_ptr];
    assign inst       = ent_data[rd_ptr];
    assign inst_pc    = ent_pc[rd_ptr];

    // which entries hold an item, and which one the returning word belongs to
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            ent_busy[i] = (count == 2'd2) || (count == 2'd1 && rd_ptr == 1'(i));
            fill_hit[i] = ent_busy[i] && !ent_dvalid[i] && bank_rvalid[ent_bank[i]];
        end
    end

    ////////////////////////////////////////////////////////////////////
    // fetch pc and buffer control
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // first sequential step lands on the reset pc
            pc_if      <= fetch_pkg::addr_t'(`RESET_PC - 32'd4);
            wr_ptr     <= 1'b0;
            rd_ptr     <= 1'b0;
            count      <= 2'd0;
            ent_dvalid <= 2'b00;
        end else begin
            if (push) begin
                pc_if  <= next_pc;
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
            for (int i = 0; i < 2; i++) begin
                if (push && wr_ptr == 1'(i)) begin
                    ent_dvalid[i] <= 1'b0;
                end else if (pop && rd_ptr == 1'(i)) begin
                    ent_dvalid[i] <= 1'b0;
                end else if (fill_hit[i]) begin
                    ent_dvalid[i] <= 1'b1;
                end
            end
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (push) begin
            ent_pc[wr_ptr]   <= next_pc;
            ent_bank[wr_ptr] <= next_bank;
        end
        for (int i = 0; i < 2; i++) begin
            if (fill_hit[i]) begin
                ent_data[i] <= bank_rdata[ent_bank[i]];
            end
        end
    end

endmodule

/* imem_bank.sv */
`include "fetch_macros.svh"

module imem_bank #(
    parameter int BANK_ID = 0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req,
    input  fetch_pkg::addr_t  addr,
    input  logic              stall,
    input  logic              wr_en,
    input  fetch_pkg::addr_t  wr_addr,
    input  fetch_pkg::inst_t  wr_data,
    output logic              addr_ok,
    output logic              rvalid,
    output fetch_pkg::inst_t  rdata
);

    // word index sits above the bank select bits
    localparam int IDX_W  = $clog2(`BANK_DEPTH);
    localparam int IDX_LO = `BANK_SEL_W + 2;

    fetch_pkg::inst_t mem [`BANK_DEPTH];

    logic             sel;
    logic             wr_sel;
    logic             accept;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    assign sel    = addr[IDX_LO-1:2] == fetch_pkg::bank_sel_t'(BANK_ID);
    assign wr_sel = wr_addr[IDX_LO-1:2] == fetch_pkg::bank_sel_t'(BANK_ID);
    assign rd_idx = addr[IDX_LO+IDX_W-1:IDX_LO];
    assign wr_idx = wr_addr[IDX_LO+IDX_W-1:IDX_LO];

    // ready for an address when selected and not stalled
    assign addr_ok = sel && !stall;
    assign accept  = req && addr_ok;

    // program load port
    always_ff @(posedge clk) begin
        if (wr_en && wr_sel) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // registered read, valid for one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else begin
            rvalid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rdata <= mem[rd_idx];
        end
    end

endmodule

/* pc_gen.sv */
module pc_gen (
    input  logic              clk,
    input  logic              rst_n,
    input  fetch_pkg::addr_t  jump_addr,
    input  logic              jump,
    input  logic              fence_flush,
    input  logic              halt,
    input  logic              clint_hold,
    input  logic              allow_in_if,
    input  logic              mem_addr_ok,
    input  fetch_pkg::addr_t  pc_if,
    output logic              rom_req,
    output fetch_pkg::addr_t  next_pc
);

    // sequential successor of the last accepted pc
    fetch_pkg::addr_t pc_add;

    // target held while fetch could not take it
    fetch_pkg::addr_t saved_addr;
    logic             saved_valid;

    logic cancel;
    logic ready_go_pre;
    logic save_jump;

    ////////////////////////////////////////////////////////////////////
    // request and next pc
    ////////////////////////////////////////////////////////////////////

    // any of these blocks a new fetch this cycle
    assign cancel = fence_flush || halt || clint_hold || !allow_in_if;

    assign rom_req = !cancel;

    assign pc_add = pc_if + fetch_pkg::addr_t'(4);

    // request leaves for the selected bank
    assign ready_go_pre = rom_req && mem_addr_ok;

    // a live jump wins over an older saved one
    always_comb begin
        if (jump) begin
            next_pc = jump_addr;
        end else if (saved_valid) begin
            next_pc = saved_addr;
        end else begin
            next_pc = pc_add;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // saved jump
    ////////////////////////////////////////////////////////////////////

    // jump pulse that did not get out this cycle
    assign save_jump = jump && !ready_go_pre;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            saved_valid <= 1'b0;
        end else if (save_jump) begin
            saved_valid <= 1'b1;
        end else if (ready_go_pre) begin
            // consumed by the accepted request
            saved_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (save_jump) begin
            saved_addr <= jump_addr;
        end
    end

endmodule

/* fetch_pkg.sv */
`include "fetch_macros.svh"

package fetch_pkg;

    ////////////////////////////////////////////////////////////////////
    // vector types shared across the fetch front end
    ////////////////////////////////////////////////////////////////////

    // fetch address
    typedef logic [`BUS_WIDTH-1:0] addr_t;

    // instruction word
    typedef logic [`BUS_WIDTH-1:0] inst_t;

    // bank index, address bits 3:2
    typedef logic [`BANK_SEL_W-1:0] bank_sel_t;

    // one bit per bank
    typedef logic [`BANK_COUNT-1:0] bank_mask_t;

endpackage

/* fetch_macros.svh */
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

////////////////////////////////////////////////////////////////////////
// fetch front end widths and sizes
////////////////////////////////////////////////////////////////////////

// address and instruction width
`define BUS_WIDTH 32

// interleaved banks, power of two
`define BANK_COUNT 4

// bank select width, log2 of the bank count
`define BANK_SEL_W 2

// words held by each bank
`define BANK_DEPTH 64

// first fetch address after reset
`define RESET_PC 32'h0000_0100

`endif
